// File: Bender.yml
package:
  name: execute_stage

export_include_dirs:
  - src

sources:
  - src/exec_pkg.sv
  - src/commit_slot.sv
  - src/alu_unit.sv
  - src/lsu_unit.sv
  - src/sfu_unit.sv
  - src/execute_stage.sv
  - target: test
    files:
      - tests/tb_execute.sv

// File: src/alu_unit.sv
// alu_unit computes per-lane integer results, resolves branches and flags ebreak for simulation
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module alu_unit import exec_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  dispatch_t   dispatch,
    input  logic        dispatch_valid,
    output logic        dispatch_ready,

    output commit_t     commit,
    output logic        commit_valid,
    input  logic        commit_ready,

    output branch_ctl_t branch_ctl,
    output logic        sim_ebreak
);

    alu_op_e     op;
    logic        accept;
    logic        is_branch;
    logic        is_trap;
    logic        lane0_eq;
    logic        taken;
    lane_data_t  result;
    commit_t     result_rec;
    branch_ctl_t branch_q;

    assign op        = alu_op_e'(dispatch.op);
    assign accept    = dispatch_valid && dispatch_ready;
    assign is_branch = (op == BEQ) || (op == BNE);
    assign is_trap   = (op == EBREAK) || (op == ECALL);

    // branch condition only looks at lane 0, all lanes of a warp share the pc
    assign lane0_eq = (dispatch.rs1[0] == dispatch.rs2[0]);
    assign taken    = (op == BEQ) ? lane0_eq : !lane0_eq;

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            result[i] = '0;
            if (dispatch.tmask[i]) begin
                case (op)
                    ADD:     result[i] = dispatch.rs1[i] + dispatch.rs2[i];
                    SUB:     result[i] = dispatch.rs1[i] - dispatch.rs2[i];
                    AND:     result[i] = dispatch.rs1[i] & dispatch.rs2[i];
                    OR:      result[i] = dispatch.rs1[i] | dispatch.rs2[i];
                    XOR:     result[i] = dispatch.rs1[i] ^ dispatch.rs2[i];
                    SLT:     result[i] = `XLEN'($signed(dispatch.rs1[i]) < $signed(dispatch.rs2[i]));
                    SLL:     result[i] = dispatch.rs1[i] << dispatch.rs2[i][4:0];
                    SRL:     result[i] = dispatch.rs1[i] >> dispatch.rs2[i][4:0];
                    default: result[i] = '0;
                endcase
            end
        end
    end

    // branches and traps write no register
    always_comb begin
        result_rec.wid   = dispatch.wid;
        result_rec.tmask = dispatch.tmask;
        result_rec.rd    = dispatch.rd;
        result_rec.wb    = !(is_branch || is_trap);
        result_rec.data  = result;
    end

    commit_slot #(
        .payload_t (commit_t)
    ) slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dispatch_valid),
        .in_data   (result_rec),
        .in_ready  (dispatch_ready),
        .out_valid (commit_valid),
        .out_data  (commit),
        .out_ready (commit_ready)
    );

    // the branch pulse lines up with the commit of the same instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            branch_q <= '0;
        end else begin
            branch_q.valid <= accept && is_branch;
            branch_q.wid   <= dispatch.wid;
            branch_q.taken <= taken;
            branch_q.dest  <= dispatch.pc + dispatch.imm;
        end
    end

    assign branch_ctl = branch_q;

    // lets a simulation stop when warp 0 reaches ebreak or ecall
    assign sim_ebreak = accept && (dispatch.wid == '0) && is_trap;

endmodule

`default_nettype wire

// File: src/commit_slot.sv
// commit_slot is a one-entry valid/ready output register for any payload type
`timescale 1ns/1ps
`default_nettype none

module commit_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     valid_q;
    payload_t data_q;

    // a full slot still takes a new item when its content leaves in the same cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

`default_nettype wire

// File: src/exec_pkg.sv
// exec_pkg holds the op encodings and the dispatch, commit, memory and control records
`include "exec_settings.svh"
`default_nettype none

package exec_pkg;

    localparam int WID_W = $clog2(`NUM_WARPS);

    typedef logic [WID_W-1:0]                   wid_t;
    typedef logic [`NUM_LANES-1:0]              tmask_t;
    typedef logic [`NUM_LANES-1:0][`XLEN-1:0]   lane_data_t;

    // the dispatch op field is 4 bits wide and each unit reads the low bits it needs
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        BEQ,
        BNE,
        EBREAK,
        ECALL
    } alu_op_e;

    typedef enum logic {
        LOAD,
        STORE
    } lsu_op_e;

    typedef enum logic [1:0] {
        TMC,
        ACC_READ,
        ACC_WRITE
    } sfu_op_e;

    typedef struct packed {
        wid_t        wid;
        tmask_t      tmask;
        logic [3:0]  op;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] imm;
        lane_data_t  rs1;
        lane_data_t  rs2;
    } dispatch_t;

    typedef struct packed {
        wid_t       wid;
        tmask_t     tmask;
        logic [4:0] rd;
        logic       wb;
        lane_data_t data;
    } commit_t;

    typedef struct packed {
        logic        valid;
        wid_t        wid;
        logic        taken;
        logic [31:0] dest;
    } branch_ctl_t;

    typedef struct packed {
        logic   valid;
        wid_t   wid;
        tmask_t tmask;
    } warp_ctl_t;

    typedef struct packed {
        logic              write;
        logic [`ADDR_W-1:0] addr;
        logic [`XLEN-1:0]   wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: src/exec_settings.svh
// execute stage settings for lane count, data width, warp count and memory address width
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// threads that run in lockstep inside one warp
`define NUM_LANES 4

// width of a register and of a memory word
`define XLEN 32

// warps tracked by the core, sets the warp id width
`define NUM_WARPS 4

// data memory is word addressed, so this counts words and not bytes
`define ADDR_W 16

`endif

// File: src/execute_stage.sv
// execute_stage places the ALU, LSU and SFU side by side behind their own dispatch and commit ports
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module execute_stage import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,

    input  dispatch_t        alu_dispatch,
    input  logic             alu_dispatch_valid,
    output logic             alu_dispatch_ready,
    output commit_t          alu_commit,
    output logic             alu_commit_valid,
    input  logic             alu_commit_ready,
    output branch_ctl_t      alu_branch_ctl,
    output logic             alu_sim_ebreak,

    input  dispatch_t        lsu_dispatch,
    input  logic             lsu_dispatch_valid,
    output logic             lsu_dispatch_ready,
    output commit_t          lsu_commit,
    output logic             lsu_commit_valid,
    input  logic             lsu_commit_ready,
    input  logic             lsu_downstream_mem_busy,
    output mem_req_t         lsu_mem_req,
    output logic             lsu_mem_req_valid,
    input  logic             lsu_mem_req_ready,
    input  logic             lsu_mem_rsp_valid,
    input  logic [`XLEN-1:0] lsu_mem_rsp_data,

    input  dispatch_t        sfu_dispatch,
    input  logic             sfu_dispatch_valid,
    output logic             sfu_dispatch_ready,
    output commit_t          sfu_commit,
    output logic             sfu_commit_valid,
    input  logic             sfu_commit_ready,
    output warp_ctl_t        sfu_warp_ctl,
    input  logic [`XLEN-1:0] sfu_acc_read_in,
    output logic [`XLEN-1:0] sfu_acc_write_out,
    output logic             sfu_acc_write_en
);

    alu_unit alu (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch       (alu_dispatch),
        .dispatch_valid (alu_dispatch_valid),
        .dispatch_ready (alu_dispatch_ready),
        .commit         (alu_commit),
        .commit_valid   (alu_commit_valid),
        .commit_ready   (alu_commit_ready),
        .branch_ctl     (alu_branch_ctl),
        .sim_ebreak     (alu_sim_ebreak)
    );

    // the only unit that talks to data memory
    lsu_unit lsu (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dispatch            (lsu_dispatch),
        .dispatch_valid      (lsu_dispatch_valid),
        .dispatch_ready      (lsu_dispatch_ready),
        .commit              (lsu_commit),
        .commit_valid        (lsu_commit_valid),
        .commit_ready        (lsu_commit_ready),
        .downstream_mem_busy (lsu_downstream_mem_busy),
        .mem_req             (lsu_mem_req),
        .mem_req_valid       (lsu_mem_req_valid),
        .mem_req_ready       (lsu_mem_req_ready),
        .mem_rsp_valid       (lsu_mem_rsp_valid),
        .mem_rsp_data        (lsu_mem_rsp_data)
    );

    sfu_unit sfu (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch       (sfu_dispatch),
        .dispatch_valid (sfu_dispatch_valid),
        .dispatch_ready (sfu_dispatch_ready),
        .commit         (sfu_commit),
        .commit_valid   (sfu_commit_valid),
        .commit_ready   (sfu_commit_ready),
        .warp_ctl       (sfu_warp_ctl),
        .acc_read_in    (sfu_acc_read_in),
        .acc_write_out  (sfu_acc_write_out),
        .acc_write_en   (sfu_acc_write_en)
    );

endmodule

`default_nettype wire

// File: src/lsu_unit.sv
// lsu_unit walks the active lanes of a warp and serializes word accesses onto one memory port
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module lsu_unit import exec_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,

    input  dispatch_t          dispatch,
    input  logic               dispatch_valid,
    output logic               dispatch_ready,

    output commit_t            commit,
    output logic               commit_valid,
    input  logic               commit_ready,

    input  logic               downstream_mem_busy,

    output mem_req_t           mem_req,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    input  logic               mem_rsp_valid,
    input  logic [`XLEN-1:0]   mem_rsp_data
);

    localparam int LANE_W = $clog2(`NUM_LANES);

    // index of the lowest set bit, lane 0 has the highest priority
    function automatic logic [LANE_W-1:0] lowest_lane(input tmask_t mask);
        logic [LANE_W-1:0] idx;
        idx = '0;
        for (int i = `NUM_LANES - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = LANE_W'(i);
            end
        end
        return idx;
    endfunction

    lsu_op_e           disp_op;
    lsu_op_e           inst_op;
    logic              accept;
    logic              busy;
    dispatch_t         inst_q;
    tmask_t            req_pending;
    tmask_t            rsp_pending;
    lane_data_t        data_q;
    logic [LANE_W-1:0] req_lane;
    logic [LANE_W-1:0] rsp_lane;
    logic              req_fire;
    logic              rsp_fire;
    logic              done;
    logic              slot_ready;
    commit_t           done_rec;

    assign disp_op = lsu_op_e'(dispatch.op[0]);
    assign inst_op = lsu_op_e'(inst_q.op[0]);

    // one instruction at a time, and only when its commit can get out afterwards
    assign dispatch_ready = !busy && slot_ready;
    assign accept         = dispatch_valid && dispatch_ready;

    assign req_lane = lowest_lane(req_pending);
    assign rsp_lane = lowest_lane(rsp_pending);

    assign mem_req_valid = busy && (|req_pending) && !downstream_mem_busy;
    assign mem_req.write = (inst_op == STORE);
    assign mem_req.addr  = inst_q.rs1[req_lane][`ADDR_W-1:0] + inst_q.imm[`ADDR_W-1:0];
    assign mem_req.wdata = inst_q.rs2[req_lane];

    assign req_fire = mem_req_valid && mem_req_ready;

    // responses come back in request order, so the lowest waiting lane owns each one
    assign rsp_fire = busy && mem_rsp_valid && (|rsp_pending);

    assign done = busy && (req_pending == '0) && (rsp_pending == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            req_pending <= '0;
            rsp_pending <= '0;
        end else if (accept) begin
            busy        <= 1'b1;
            req_pending <= dispatch.tmask;
            rsp_pending <= (disp_op == LOAD) ? dispatch.tmask : '0;
        end else if (busy) begin
            if (req_fire) begin
                req_pending[req_lane] <= 1'b0;
            end
            if (rsp_fire) begin
                rsp_pending[rsp_lane] <= 1'b0;
            end
            if (done && slot_ready) begin
                busy <= 1'b0;
            end
        end
    end

    // inactive lanes keep the zero written at dispatch
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= dispatch;
            data_q <= '0;
        end else if (rsp_fire) begin
            data_q[rsp_lane] <= mem_rsp_data;
        end
    end

    always_comb begin
        done_rec.wid   = inst_q.wid;
        done_rec.tmask = inst_q.tmask;
        done_rec.rd    = inst_q.rd;
        done_rec.wb    = (inst_op == LOAD);
        done_rec.data  = data_q;
    end

    commit_slot #(
        .payload_t (commit_t)
    ) slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (done),
        .in_data   (done_rec),
        .in_ready  (slot_ready),
        .out_valid (commit_valid),
        .out_data  (commit),
        .out_ready (commit_ready)
    );

endmodule

`default_nettype wire

// File: src/sfu_unit.sv
// sfu_unit handles thread-mask control and reads and writes of the external accumulator
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module sfu_unit import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,

    input  dispatch_t        dispatch,
    input  logic             dispatch_valid,
    output logic             dispatch_ready,

    output commit_t          commit,
    output logic             commit_valid,
    input  logic             commit_ready,

    output warp_ctl_t        warp_ctl,

    input  logic [`XLEN-1:0] acc_read_in,
    output logic [`XLEN-1:0] acc_write_out,
    output logic             acc_write_en
);

    sfu_op_e          op;
    logic             accept;
    commit_t          result_rec;
    warp_ctl_t        warp_ctl_q;
    logic             acc_en_q;
    logic [`XLEN-1:0] acc_data_q;

    assign op     = sfu_op_e'(dispatch.op[1:0]);
    assign accept = dispatch_valid && dispatch_ready;

    // only an accumulator read writes back, every active lane gets the same value
    always_comb begin
        result_rec.wid   = dispatch.wid;
        result_rec.tmask = dispatch.tmask;
        result_rec.rd    = dispatch.rd;
        result_rec.wb    = (op == ACC_READ);
        for (int i = 0; i < `NUM_LANES; i++) begin
            result_rec.data[i] = (result_rec.wb && dispatch.tmask[i]) ? acc_read_in : '0;
        end
    end

    commit_slot #(
        .payload_t (commit_t)
    ) slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dispatch_valid),
        .in_data   (result_rec),
        .in_ready  (dispatch_ready),
        .out_valid (commit_valid),
        .out_data  (commit),
        .out_ready (commit_ready)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            warp_ctl_q <= '0;
            acc_en_q   <= 1'b0;
        end else begin
            warp_ctl_q.valid <= accept && (op == TMC);
            warp_ctl_q.wid   <= dispatch.wid;
            // new thread mask comes from the low bits of lane 0
            warp_ctl_q.tmask <= dispatch.rs1[0][`NUM_LANES-1:0];
            acc_en_q         <= accept && (op == ACC_WRITE);
        end
    end

    // the written value holds until the next accumulator write
    always_ff @(posedge clk) begin
        if (accept && (op == ACC_WRITE)) begin
            acc_data_q <= dispatch.rs1[0];
        end
    end

    assign warp_ctl      = warp_ctl_q;
    assign acc_write_en  = acc_en_q;
    assign acc_write_out = acc_data_q;

endmodule

`default_nettype wire

// File: tests/tb_execute.sv
// testbench for the execute stage with random dispatch, a memory model and a reference model
`timescale 1ns/1ps
`include "exec_settings.svh"
`default_nettype none

module tb_execute import exec_pkg::*; ();

    localparam int RUN_CYCLES    = 3000;
    localparam int DRAIN_TIMEOUT = 1000;

    logic             clk;
    logic             rst_n;
    dispatch_t        alu_dispatch;
    logic             alu_dispatch_valid;
    logic             alu_dispatch_ready;
    commit_t          alu_commit;
    logic             alu_commit_valid;
    logic             alu_commit_ready;
    branch_ctl_t      alu_branch_ctl;
    logic             alu_sim_ebreak;
    dispatch_t        lsu_dispatch;
    logic             lsu_dispatch_valid;
    logic             lsu_dispatch_ready;
    commit_t          lsu_commit;
    logic             lsu_commit_valid;
    logic             lsu_commit_ready;
    logic             lsu_downstream_mem_busy;
    mem_req_t         lsu_mem_req;
    logic             lsu_mem_req_valid;
    logic             lsu_mem_req_ready;
    logic             lsu_mem_rsp_valid;
    logic [`XLEN-1:0] lsu_mem_rsp_data;
    dispatch_t        sfu_dispatch;
    logic             sfu_dispatch_valid;
    logic             sfu_dispatch_ready;
    commit_t          sfu_commit;
    logic             sfu_commit_valid;
    logic             sfu_commit_ready;
    warp_ctl_t        sfu_warp_ctl;
    logic [`XLEN-1:0] sfu_acc_read_in;
    logic [`XLEN-1:0] sfu_acc_write_out;
    logic             sfu_acc_write_en;

    integer seed = 88614;
    int     errors;
    int     cycle;
    int     last_due;
    int     alu_accepts, lsu_accepts, sfu_accepts;
    int     alu_commits, lsu_commits, sfu_commits;
    bit     alu_pending, lsu_pending, sfu_pending;

    // memory seen by the DUT and the reference copy updated at dispatch
    logic [`XLEN-1:0] mem [0:65535];
    logic [`XLEN-1:0] ref_mem [0:65535];

    commit_t          alu_exp_q[$];
    commit_t          lsu_exp_q[$];
    commit_t          sfu_exp_q[$];
    mem_req_t         req_exp_q[$];
    logic [`XLEN-1:0] rsp_data_q[$];
    int               rsp_due_q[$];

    // pulse expectations that apply one cycle after the accept
    branch_ctl_t      exp_branch;
    warp_ctl_t        exp_warp;
    logic             exp_acc_en;
    logic [`XLEN-1:0] exp_acc_data;

    execute_stage dut0 (.*);

    always #2 clk = ~clk;

    task automatic check_commit(input string unit, input commit_t got, input commit_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s commit got %h expected %h", $time, unit, got, exp);
        end
    endtask

    task automatic check_branch(input branch_ctl_t got, input branch_ctl_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            errors++;
            $display("Mismatch at %0t: branch_ctl got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_warp_ctl(input warp_ctl_t got, input warp_ctl_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            errors++;
            $display("Mismatch at %0t: warp_ctl got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_acc(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: acc_write_out got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // write data only matters for stores
    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got.write !== exp.write || got.addr !== exp.addr
                || (exp.write && got.wdata !== exp.wdata)) begin
            errors++;
            $display("Mismatch at %0t: mem_req got %h expected %h", $time, got, exp);
        end
    endtask

    function automatic dispatch_t random_dispatch(input int n_ops, input bit small_addr);
        dispatch_t d;
        d.wid   = wid_t'($random(seed));
        d.tmask = tmask_t'($random(seed));
        d.op    = 4'({$random(seed)} % n_ops);
        d.rd    = 5'($random(seed));
        d.pc    = $random(seed);
        d.imm   = small_addr ? {$random(seed)} % 8 : $random(seed);
        for (int i = 0; i < `NUM_LANES; i++) begin
            d.rs1[i] = small_addr ? {$random(seed)} % 16 : $random(seed);
            d.rs2[i] = $random(seed);
        end
        // equal lane-0 operands make taken branches common
        if ($random(seed) & 1) begin
            d.rs2[0] = d.rs1[0];
        end
        return d;
    endfunction

    function automatic commit_t alu_model(input dispatch_t d);
        commit_t          c;
        alu_op_e          op;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        op      = alu_op_e'(d.op);
        c.wid   = d.wid;
        c.tmask = d.tmask;
        c.rd    = d.rd;
        c.wb    = (d.op <= 4'd7);
        c.data  = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            a = d.rs1[i];
            b = d.rs2[i];
            if (d.tmask[i]) begin
                case (op)
                    ADD:     c.data[i] = a + b;
                    SUB:     c.data[i] = a - b;
                    AND:     c.data[i] = a & b;
                    OR:      c.data[i] = a | b;
                    XOR:     c.data[i] = a ^ b;
                    SLT:     c.data[i] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    SLL:     c.data[i] = a << b[4:0];
                    SRL:     c.data[i] = a >> b[4:0];
                    default: c.data[i] = '0;
                endcase
            end
        end
        return c;
    endfunction

    // requests go out lowest lane first, so later lanes win on a shared address
    task automatic lsu_model(input dispatch_t d, output commit_t c);
        mem_req_t          r;
        logic [`ADDR_W-1:0] addr;
        c.wid   = d.wid;
        c.tmask = d.tmask;
        c.rd    = d.rd;
        c.wb    = (lsu_op_e'(d.op[0]) == LOAD);
        c.data  = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (d.tmask[i]) begin
                addr    = d.rs1[i][`ADDR_W-1:0] + d.imm[`ADDR_W-1:0];
                r.write = !c.wb;
                r.addr  = addr;
                r.wdata = d.rs2[i];
                req_exp_q.push_back(r);
                if (c.wb) begin
                    c.data[i] = ref_mem[addr];
                end else begin
                    ref_mem[addr] = d.rs2[i];
                end
            end
        end
    endtask

    function automatic commit_t sfu_model(input dispatch_t d, input logic [`XLEN-1:0] acc);
        commit_t c;
        c.wid   = d.wid;
        c.tmask = d.tmask;
        c.rd    = d.rd;
        c.wb    = (sfu_op_e'(d.op[1:0]) == ACC_READ);
        c.data  = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (c.wb && d.tmask[i]) begin
                c.data[i] = acc;
            end
        end
        return c;
    endfunction

    task automatic drive_inputs(input bit allow_new);
        cycle++;
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
            lsu_mem_rsp_valid = 1'b1;
            lsu_mem_rsp_data  = rsp_data_q.pop_front();
            void'(rsp_due_q.pop_front());
        end else begin
            lsu_mem_rsp_valid = 1'b0;
            lsu_mem_rsp_data  = $random(seed);
        end
        lsu_mem_req_ready       = ({$random(seed)} % 4) != 0;
        lsu_downstream_mem_busy = ({$random(seed)} % 4) == 0;
        alu_commit_ready        = ({$random(seed)} % 4) != 0;
        lsu_commit_ready        = ({$random(seed)} % 4) != 0;
        sfu_commit_ready        = ({$random(seed)} % 4) != 0;
        sfu_acc_read_in         = $random(seed);
        // a dispatch taken on the last rising edge drops its valid here
        if (!alu_pending) begin
            alu_dispatch_valid = 1'b0;
        end
        if (!lsu_pending) begin
            lsu_dispatch_valid = 1'b0;
        end
        if (!sfu_pending) begin
            sfu_dispatch_valid = 1'b0;
        end
        // a raised valid holds its data until the unit takes it
        if (!alu_pending && allow_new && ($random(seed) & 1)) begin
            alu_dispatch       = random_dispatch(12, 1'b0);
            alu_dispatch_valid = 1'b1;
            alu_pending        = 1'b1;
        end
        if (!lsu_pending && allow_new && ($random(seed) & 1)) begin
            lsu_dispatch       = random_dispatch(2, 1'b1);
            lsu_dispatch_valid = 1'b1;
            lsu_pending        = 1'b1;
        end
        if (!sfu_pending && allow_new && ($random(seed) & 1)) begin
            sfu_dispatch       = random_dispatch(3, 1'b0);
            sfu_dispatch_valid = 1'b1;
            sfu_pending        = 1'b1;
        end
    endtask

    task automatic sample_outputs();
        commit_t  c;
        logic     accept;
        logic     trap;
        int       delay;
        check_branch(alu_branch_ctl, exp_branch);
        check_warp_ctl(sfu_warp_ctl, exp_warp);
        check_flag("acc_write_en", sfu_acc_write_en, exp_acc_en);
        if (exp_acc_en) begin
            check_acc(sfu_acc_write_out, exp_acc_data);
        end
        exp_branch = '0;
        exp_warp   = '0;
        exp_acc_en = 1'b0;

        accept = alu_dispatch_valid && alu_dispatch_ready;
        trap   = alu_op_e'(alu_dispatch.op) inside {EBREAK, ECALL};
        check_flag("sim_ebreak", alu_sim_ebreak, accept && trap && alu_dispatch.wid == '0);
        if (accept) begin
            alu_exp_q.push_back(alu_model(alu_dispatch));
            alu_accepts++;
            alu_pending = 1'b0;
            if (alu_op_e'(alu_dispatch.op) inside {BEQ, BNE}) begin
                exp_branch.valid = 1'b1;
                exp_branch.wid   = alu_dispatch.wid;
                exp_branch.taken = (alu_dispatch.rs1[0] == alu_dispatch.rs2[0])
                                   ^ (alu_op_e'(alu_dispatch.op) == BNE);
                exp_branch.dest  = alu_dispatch.pc + alu_dispatch.imm;
            end
        end

        if (lsu_dispatch_valid && lsu_dispatch_ready) begin
            lsu_model(lsu_dispatch, c);
            lsu_exp_q.push_back(c);
            lsu_accepts++;
            lsu_pending = 1'b0;
        end

        if (sfu_dispatch_valid && sfu_dispatch_ready) begin
            sfu_exp_q.push_back(sfu_model(sfu_dispatch, sfu_acc_read_in));
            sfu_accepts++;
            sfu_pending    = 1'b0;
            exp_warp.valid = (sfu_op_e'(sfu_dispatch.op[1:0]) == TMC);
            exp_warp.wid   = sfu_dispatch.wid;
            exp_warp.tmask = sfu_dispatch.rs1[0][`NUM_LANES-1:0];
            exp_acc_en     = (sfu_op_e'(sfu_dispatch.op[1:0]) == ACC_WRITE);
            exp_acc_data   = sfu_dispatch.rs1[0];
        end

        if (lsu_mem_req_valid && lsu_downstream_mem_busy) begin
            errors++;
            $display("Memory request issued at %0t while downstream memory is busy", $time);
        end
        if (lsu_mem_req_valid && lsu_mem_req_ready) begin
            if (req_exp_q.size() == 0) begin
                errors++;
                $display("Unexpected memory request at %0t", $time);
            end else begin
                check_mem_req(lsu_mem_req, req_exp_q.pop_front());
            end
            if (lsu_mem_req.write) begin
                mem[lsu_mem_req.addr] = lsu_mem_req.wdata;
            end else begin
                delay    = 1 + {$random(seed)} % 4;
                last_due = (cycle + delay > last_due) ? cycle + delay : last_due;
                rsp_data_q.push_back(mem[lsu_mem_req.addr]);
                rsp_due_q.push_back(last_due);
            end
        end

        if (alu_commit_valid && alu_commit_ready) begin
            alu_commits++;
            if (alu_exp_q.size() == 0) begin
                errors++;
                $display("ALU committed at %0t with nothing outstanding", $time);
            end else begin
                check_commit("alu", alu_commit, alu_exp_q.pop_front());
            end
        end
        if (lsu_commit_valid && lsu_commit_ready) begin
            lsu_commits++;
            if (lsu_exp_q.size() == 0) begin
                errors++;
                $display("LSU committed at %0t with nothing outstanding", $time);
            end else begin
                check_commit("lsu", lsu_commit, lsu_exp_q.pop_front());
            end
        end
        if (sfu_commit_valid && sfu_commit_ready) begin
            sfu_commits++;
            if (sfu_exp_q.size() == 0) begin
                errors++;
                $display("SFU committed at %0t with nothing outstanding", $time);
            end else begin
                check_commit("sfu", sfu_commit, sfu_exp_q.pop_front());
            end
        end
    endtask

    function automatic bit all_idle();
        return !alu_pending && !lsu_pending && !sfu_pending
            && alu_exp_q.size() == 0 && lsu_exp_q.size() == 0 && sfu_exp_q.size() == 0
            && req_exp_q.size() == 0 && rsp_due_q.size() == 0;
    endfunction

    initial begin
        int waited;
        clk                     = 1'b0;
        rst_n                   = 1'b0;
        alu_dispatch            = '0;
        alu_dispatch_valid      = 1'b0;
        alu_commit_ready        = 1'b0;
        lsu_dispatch            = '0;
        lsu_dispatch_valid      = 1'b0;
        lsu_commit_ready        = 1'b0;
        lsu_downstream_mem_busy = 1'b0;
        lsu_mem_req_ready       = 1'b0;
        lsu_mem_rsp_valid       = 1'b0;
        lsu_mem_rsp_data        = '0;
        sfu_dispatch            = '0;
        sfu_dispatch_valid      = 1'b0;
        sfu_commit_ready        = 1'b0;
        sfu_acc_read_in         = '0;
        exp_branch              = '0;
        exp_warp                = '0;
        exp_acc_en              = 1'b0;
        exp_acc_data            = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a]     = {~a[15:0], a[15:0]};
            ref_mem[a] = {~a[15:0], a[15:0]};
        end

        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < RUN_CYCLES; n++) begin
            @(negedge clk);
            drive_inputs(1'b1);
            #1;
            sample_outputs();
        end

        // no new work is issued while everything in flight finishes
        waited = 0;
        while (!all_idle() && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            drive_inputs(1'b0);
            #1;
            sample_outputs();
            waited++;
        end
        if (!all_idle()) begin
            errors++;
            $display("Timeout: units still busy after %0d drain cycles", DRAIN_TIMEOUT);
        end

        if (alu_commits != alu_accepts || lsu_commits != lsu_accepts
                || sfu_commits != sfu_accepts) begin
            errors++;
            $display("Commit counts do not match accepted dispatch counts");
        end

        $display("errors %0d, alu %0d/%0d, lsu %0d/%0d, sfu %0d/%0d commits/dispatches",
                 errors, alu_commits, alu_accepts, lsu_commits, lsu_accepts,
                 sfu_commits, sfu_accepts);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/exec_pkg.sv
src/commit_slot.sv
src/alu_unit.sv
src/lsu_unit.sv
src/sfu_unit.sv
src/execute_stage.sv
tests/tb_execute.sv
